//--- rtl/tlb_config.svh
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

// ------------------------------
// entry counts
// ------------------------------
`define TLB_SECT_ENTRIES  8   // sectored 4 KiB entries
`define TLB_SUPER_ENTRIES 4   // megapage entries
`define TLB_SECTOR_NUM    4   // pages per sectored entry

// ------------------------------
// Sv32 address geometry
// ------------------------------
`define VADDR_W     32
`define PADDR_W     34
`define PG_IDX_W    12
`define VPN_FIELD_W 10  // one level of the VPN

`endif

//--- rtl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

`include "tlb_config.svh"

  typedef logic [`VADDR_W-1:0] vaddr_t;
  typedef logic [`PADDR_W-1:0] paddr_t;
  typedef logic [`VADDR_W-`PG_IDX_W-1:0] vpn_t;  // VPN[1] & VPN[0]
  typedef logic [`PADDR_W-`PG_IDX_W-1:0] ppn_t;

  // raw Sv32 PTE as returned by the walker
  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  typedef logic [0:0] pg_level_t;  // 0 megapage leaf, 1 4 KiB leaf

  typedef logic [1:0] priv_t;

  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_S = 2'd1;
  localparam priv_t PRIV_M = 2'd3;

endpackage

`default_nettype wire

//--- rtl/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

`include "tlb_config.svh"

  import mmu_pkg::*;

  typedef enum logic [1:0] {
    CMD_LOAD  = 2'd0,
    CMD_STORE = 2'd1,
    CMD_FETCH = 2'd2
  } tlb_cmd_t;

  // ------------------------------
  // per-sector entry data
  // ------------------------------
  typedef struct packed {
    ppn_t ppn;
    logic u;
    logic ae;  // walker hit an access fault
    logic sr;
    logic sw;  // W and D both set
    logic sx;
  } tlb_data_t;

  typedef logic [$clog2(`TLB_SECTOR_NUM)-1:0] sector_idx_t;
  typedef logic [`TLB_SECTOR_NUM-1:0] sect_valid_t;

  // refill sequencing
  typedef enum logic [1:0] {
    ST_READY           = 2'd0,
    ST_REQUEST         = 2'd1,
    ST_WAIT            = 2'd2,
    ST_WAIT_INVALIDATE = 2'd3
  } tlb_state_t;

endpackage

`default_nettype wire

//--- rtl/tlb_lookup.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_config.svh"

module tlb_lookup
  import mmu_pkg::*;
  import tlb_pkg::*;
(
  input  vaddr_t      i_req_vaddr,
  input  priv_t       i_priv,
  input  logic        i_satp_mode,
  input  sect_valid_t i_sect_valid [`TLB_SECT_ENTRIES],
  input  vpn_t        i_sect_tag   [`TLB_SECT_ENTRIES],
  input  tlb_data_t [`TLB_SECTOR_NUM-1:0] i_sect_data [`TLB_SECT_ENTRIES],
  input  logic        i_super_valid [`TLB_SUPER_ENTRIES],
  input  vpn_t        i_super_tag   [`TLB_SUPER_ENTRIES],
  input  tlb_data_t   i_super_data  [`TLB_SUPER_ENTRIES],
  output vpn_t        o_vpn,
  output logic        o_hit,
  output tlb_data_t   o_hit_data,
  output paddr_t      o_paddr,
  output logic        o_miss
);

  localparam int VPN_W  = `VADDR_W - `PG_IDX_W;
  localparam int PPN_W  = `PADDR_W - `PG_IDX_W;
  localparam int SECT_W = $clog2(`TLB_SECTOR_NUM);

  vpn_t        w_vpn;
  sector_idx_t w_sector;
  logic        w_vm_on;
  logic [`TLB_SECT_ENTRIES-1:0]  w_sect_hit;
  logic [`TLB_SUPER_ENTRIES-1:0] w_super_hit;
  logic        w_any_hit;
  tlb_data_t   w_sel_data;
  ppn_t        w_sel_ppn;

  assign w_vpn    = i_req_vaddr[`VADDR_W-1:`PG_IDX_W];
  assign w_sector = w_vpn[SECT_W-1:0];
  assign w_vm_on  = i_satp_mode & (i_priv != PRIV_M);

  // ------------------------------
  // tag match
  // ------------------------------
  for (genvar e = 0; e < `TLB_SECT_ENTRIES; e++) begin : g_sect
    assign w_sect_hit[e] = i_sect_valid[e][w_sector] &
                           (i_sect_tag[e][VPN_W-1:SECT_W] == w_vpn[VPN_W-1:SECT_W]);
  end

  for (genvar e = 0; e < `TLB_SUPER_ENTRIES; e++) begin : g_super
    // VPN[1] only
    assign w_super_hit[e] = i_super_valid[e] &
                            (i_super_tag[e][VPN_W-1:`VPN_FIELD_W] == w_vpn[VPN_W-1:`VPN_FIELD_W]);
  end

  assign w_any_hit = (|w_sect_hit) | (|w_super_hit);

  // one-hot OR select of data and ppn
  always_comb begin
    w_sel_data = '0;
    w_sel_ppn  = '0;
    for (int e = 0; e < `TLB_SECT_ENTRIES; e++) begin
      if (w_sect_hit[e]) begin
        w_sel_data = tlb_data_t'(w_sel_data | i_sect_data[e][w_sector]);
        w_sel_ppn  = w_sel_ppn | i_sect_data[e][w_sector].ppn;
      end
    end
    for (int e = 0; e < `TLB_SUPER_ENTRIES; e++) begin
      if (w_super_hit[e]) begin
        w_sel_data = tlb_data_t'(w_sel_data | i_super_data[e]);
        w_sel_ppn  = w_sel_ppn | {i_super_data[e].ppn[PPN_W-1:`VPN_FIELD_W],
                                  w_vpn[`VPN_FIELD_W-1:0]};  // VPN[0] passes through
      end
    end
  end

  assign o_vpn      = w_vpn;
  assign o_hit      = w_vm_on & w_any_hit;
  assign o_hit_data = w_sel_data;
  assign o_miss     = w_vm_on & ~w_any_hit;
  assign o_paddr    = w_vm_on ? {w_sel_ppn, i_req_vaddr[`PG_IDX_W-1:0]} :
                                {{(`PADDR_W-`VADDR_W){1'b0}}, i_req_vaddr};

endmodule

`default_nettype wire

//--- rtl/tlb_entry_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_config.svh"

module tlb_entry_store
  import mmu_pkg::*;
  import tlb_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_sfence_valid,
  input  logic        i_refill_write,
  input  vpn_t        i_refill_vpn,
  input  pte_t        i_ptw_resp_pte,
  input  pg_level_t   i_ptw_resp_level,
  input  logic        i_ptw_resp_ae,
  output sect_valid_t o_sect_valid [`TLB_SECT_ENTRIES],
  output vpn_t        o_sect_tag   [`TLB_SECT_ENTRIES],
  output tlb_data_t [`TLB_SECTOR_NUM-1:0] o_sect_data [`TLB_SECT_ENTRIES],
  output logic        o_super_valid [`TLB_SUPER_ENTRIES],
  output vpn_t        o_super_tag   [`TLB_SUPER_ENTRIES],
  output tlb_data_t   o_super_data  [`TLB_SUPER_ENTRIES]
);

  localparam int SECT_W       = $clog2(`TLB_SECTOR_NUM);
  localparam int SECT_IDX_W   = $clog2(`TLB_SECT_ENTRIES);
  localparam int SUPER_IDX_W  = $clog2(`TLB_SUPER_ENTRIES);

  sect_valid_t r_sect_valid [`TLB_SECT_ENTRIES];
  vpn_t        r_sect_tag   [`TLB_SECT_ENTRIES];
  tlb_data_t [`TLB_SECTOR_NUM-1:0] r_sect_data [`TLB_SECT_ENTRIES];
  logic        r_super_valid [`TLB_SUPER_ENTRIES];
  vpn_t        r_super_tag   [`TLB_SUPER_ENTRIES];
  tlb_data_t   r_super_data  [`TLB_SUPER_ENTRIES];

  logic        w_is_leaf;
  tlb_data_t   w_new_data;
  sector_idx_t w_wr_sector;
  sect_valid_t w_wr_onehot;
  logic        w_sect_write;
  logic        w_super_write;
  logic [SECT_IDX_W-1:0]  w_sect_victim;
  logic [SUPER_IDX_W-1:0] w_super_victim;

  // ------------------------------
  // PTE to entry data
  // ------------------------------
  assign w_is_leaf = i_ptw_resp_pte.v & i_ptw_resp_pte.a &
                     (i_ptw_resp_pte.r | (i_ptw_resp_pte.x & ~i_ptw_resp_pte.w));

  assign w_new_data.ppn = i_ptw_resp_pte.ppn;
  assign w_new_data.u   = i_ptw_resp_pte.u;
  assign w_new_data.ae  = i_ptw_resp_ae;
  assign w_new_data.sr  = w_is_leaf & i_ptw_resp_pte.r;
  assign w_new_data.sw  = w_is_leaf & i_ptw_resp_pte.w & i_ptw_resp_pte.d;
  assign w_new_data.sx  = w_is_leaf & i_ptw_resp_pte.x;

  assign w_wr_sector   = i_refill_vpn[SECT_W-1:0];
  assign w_sect_write  = i_refill_write & (i_ptw_resp_level == 1'b1);
  assign w_super_write = i_refill_write & (i_ptw_resp_level == 1'b0);

  always_comb begin
    w_wr_onehot = '0;
    w_wr_onehot[w_wr_sector] = 1'b1;
  end

  // lowest invalid entry, 0 when full
  always_comb begin
    w_sect_victim  = '0;
    w_super_victim = '0;
    for (int e = `TLB_SECT_ENTRIES - 1; e >= 0; e--) begin
      if (~|r_sect_valid[e]) w_sect_victim = SECT_IDX_W'(e);
    end
    for (int e = `TLB_SUPER_ENTRIES - 1; e >= 0; e--) begin
      if (~r_super_valid[e]) w_super_victim = SUPER_IDX_W'(e);
    end
  end

  // ------------------------------
  // valid bits
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < `TLB_SECT_ENTRIES; e++) r_sect_valid[e] <= '0;
      for (int e = 0; e < `TLB_SUPER_ENTRIES; e++) r_super_valid[e] <= 1'b0;
    end else if (i_sfence_valid) begin  // flush beats refill
      for (int e = 0; e < `TLB_SECT_ENTRIES; e++) r_sect_valid[e] <= '0;
      for (int e = 0; e < `TLB_SUPER_ENTRIES; e++) r_super_valid[e] <= 1'b0;
    end else if (w_sect_write) begin
      r_sect_valid[w_sect_victim] <= w_wr_onehot;  // new tag, other sectors dropped
    end else if (w_super_write) begin
      r_super_valid[w_super_victim] <= 1'b1;
    end
  end

  // tags and data
  always_ff @(posedge i_clk) begin
    if (w_sect_write) begin
      r_sect_tag[w_sect_victim]               <= i_refill_vpn;
      r_sect_data[w_sect_victim][w_wr_sector] <= w_new_data;
    end
    if (w_super_write) begin
      r_super_tag[w_super_victim]  <= i_refill_vpn;
      r_super_data[w_super_victim] <= w_new_data;
    end
  end

  assign o_sect_valid  = r_sect_valid;
  assign o_sect_tag    = r_sect_tag;
  assign o_sect_data   = r_sect_data;
  assign o_super_valid = r_super_valid;
  assign o_super_tag   = r_super_tag;
  assign o_super_data  = r_super_data;

endmodule

`default_nettype wire

//--- rtl/tlb_refill_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_refill_ctrl
  import mmu_pkg::*;
  import tlb_pkg::*;
(
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_req_valid,
  input  logic i_miss,
  input  vpn_t i_vpn,
  input  logic i_kill,
  input  logic i_sfence_valid,
  input  logic i_ptw_req_ready,
  input  logic i_ptw_resp_valid,
  output logic o_ready,
  output logic o_ptw_req_valid,
  output vpn_t o_ptw_req_vpn,
  output logic o_refill_write,
  output logic o_tlb_update
);

  tlb_state_t r_state;
  tlb_state_t r_state_dly;
  vpn_t       r_refill_tag;
  logic       w_start;

  assign w_start = (r_state == ST_READY) & i_req_valid & i_miss;

  // ------------------------------
  // refill FSM
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= ST_READY;
      r_state_dly <= ST_READY;
    end else begin
      r_state_dly <= r_state;
      case (r_state)
        ST_READY: begin
          if (w_start) r_state <= ST_REQUEST;
        end
        ST_REQUEST: begin
          if (i_kill) begin
            r_state <= ST_READY;
          end else if (i_ptw_req_ready) begin
            r_state <= i_sfence_valid ? ST_WAIT_INVALIDATE : ST_WAIT;
          end else if (i_sfence_valid) begin
            r_state <= ST_READY;  // walk never accepted
          end
        end
        ST_WAIT: begin
          if (i_ptw_resp_valid) begin
            r_state <= ST_READY;
          end else if (i_sfence_valid) begin
            r_state <= ST_WAIT_INVALIDATE;
          end
        end
        ST_WAIT_INVALIDATE: begin
          if (i_ptw_resp_valid) r_state <= ST_READY;  // reply discarded
        end
        default: r_state <= ST_READY;
      endcase
    end
  end

  // refill tag, held for the whole walk
  always_ff @(posedge i_clk) begin
    if (w_start) r_refill_tag <= i_vpn;
  end

  assign o_ready         = (r_state == ST_READY);
  assign o_ptw_req_valid = (r_state == ST_REQUEST);
  assign o_ptw_req_vpn   = r_refill_tag;
  assign o_refill_write  = (r_state == ST_WAIT) & i_ptw_resp_valid & ~i_sfence_valid;

  // only after a reply, so kill or early sfence give no pulse
  assign o_tlb_update = (r_state == ST_READY) &
                        ((r_state_dly == ST_WAIT) | (r_state_dly == ST_WAIT_INVALIDATE));

endmodule

`default_nettype wire

//--- rtl/tlb_perm_check.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_perm_check
  import mmu_pkg::*;
  import tlb_pkg::*;
(
  input  tlb_cmd_t  i_req_cmd,
  input  priv_t     i_priv,
  input  logic      i_status_sum,
  input  logic      i_status_mxr,
  input  logic      i_hit,
  input  tlb_data_t i_hit_data,
  output logic      o_page_fault,
  output logic      o_access_fault
);

  logic w_priv_u;
  logic w_priv_s;
  logic w_rw_priv_ok;
  logic w_x_priv_ok;
  logic w_perm_ok;

  assign w_priv_u = (i_priv == PRIV_U);
  assign w_priv_s = (i_priv == PRIV_S);

  // U pages reachable from S only with SUM, and never executable there
  assign w_rw_priv_ok = i_hit_data.u ? (w_priv_u | (w_priv_s & i_status_sum)) : w_priv_s;
  assign w_x_priv_ok  = i_hit_data.u ? w_priv_u : w_priv_s;

  always_comb begin
    case (i_req_cmd)
      CMD_LOAD:  w_perm_ok = w_rw_priv_ok &
                             (i_hit_data.sr | (i_status_mxr & i_hit_data.sx));
      CMD_STORE: w_perm_ok = w_rw_priv_ok & i_hit_data.sw;
      CMD_FETCH: w_perm_ok = w_x_priv_ok & i_hit_data.sx;
      default:   w_perm_ok = 1'b0;
    endcase
  end

  assign o_page_fault   = i_hit & ~i_hit_data.ae & ~w_perm_ok;
  assign o_access_fault = i_hit & i_hit_data.ae;

endmodule

`default_nettype wire

//--- rtl/tlb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_config.svh"

module tlb_top
  import mmu_pkg::*;
  import tlb_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_req_valid,
  input  vaddr_t    i_req_vaddr,
  input  tlb_cmd_t  i_req_cmd,
  input  priv_t     i_priv,
  input  logic      i_satp_mode,
  input  logic      i_status_sum,
  input  logic      i_status_mxr,
  input  logic      i_sfence_valid,
  input  logic      i_kill,
  input  logic      i_ptw_req_ready,
  input  logic      i_ptw_resp_valid,
  input  pte_t      i_ptw_resp_pte,
  input  pg_level_t i_ptw_resp_level,
  input  logic      i_ptw_resp_ae,
  output logic      o_ready,
  output paddr_t    o_paddr,
  output logic      o_miss,
  output logic      o_page_fault,
  output logic      o_access_fault,
  output logic      o_ptw_req_valid,
  output vpn_t      o_ptw_req_vpn,
  output logic      o_tlb_update
);

  sect_valid_t w_sect_valid [`TLB_SECT_ENTRIES];
  vpn_t        w_sect_tag   [`TLB_SECT_ENTRIES];
  tlb_data_t [`TLB_SECTOR_NUM-1:0] w_sect_data [`TLB_SECT_ENTRIES];
  logic        w_super_valid [`TLB_SUPER_ENTRIES];
  vpn_t        w_super_tag   [`TLB_SUPER_ENTRIES];
  tlb_data_t   w_super_data  [`TLB_SUPER_ENTRIES];

  vpn_t      w_vpn;
  logic      w_hit;
  tlb_data_t w_hit_data;
  logic      w_refill_write;

  tlb_lookup u_lookup (
    .i_req_vaddr   (i_req_vaddr),
    .i_priv        (i_priv),
    .i_satp_mode   (i_satp_mode),
    .i_sect_valid  (w_sect_valid),
    .i_sect_tag    (w_sect_tag),
    .i_sect_data   (w_sect_data),
    .i_super_valid (w_super_valid),
    .i_super_tag   (w_super_tag),
    .i_super_data  (w_super_data),
    .o_vpn         (w_vpn),
    .o_hit         (w_hit),
    .o_hit_data    (w_hit_data),
    .o_paddr       (o_paddr),
    .o_miss        (o_miss)
  );

  tlb_entry_store u_entry_store (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_sfence_valid   (i_sfence_valid),
    .i_refill_write   (w_refill_write),
    .i_refill_vpn     (o_ptw_req_vpn),  // refill tag
    .i_ptw_resp_pte   (i_ptw_resp_pte),
    .i_ptw_resp_level (i_ptw_resp_level),
    .i_ptw_resp_ae    (i_ptw_resp_ae),
    .o_sect_valid     (w_sect_valid),
    .o_sect_tag       (w_sect_tag),
    .o_sect_data      (w_sect_data),
    .o_super_valid    (w_super_valid),
    .o_super_tag      (w_super_tag),
    .o_super_data     (w_super_data)
  );

  tlb_refill_ctrl u_refill_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_valid      (i_req_valid),
    .i_miss           (o_miss),
    .i_vpn            (w_vpn),
    .i_kill           (i_kill),
    .i_sfence_valid   (i_sfence_valid),
    .i_ptw_req_ready  (i_ptw_req_ready),
    .i_ptw_resp_valid (i_ptw_resp_valid),
    .o_ready          (o_ready),
    .o_ptw_req_valid  (o_ptw_req_valid),
    .o_ptw_req_vpn    (o_ptw_req_vpn),
    .o_refill_write   (w_refill_write),
    .o_tlb_update     (o_tlb_update)
  );

  tlb_perm_check u_perm_check (
    .i_req_cmd      (i_req_cmd),
    .i_priv         (i_priv),
    .i_status_sum   (i_status_sum),
    .i_status_mxr   (i_status_mxr),
    .i_hit          (w_hit),
    .i_hit_data     (w_hit_data),
    .o_page_fault   (o_page_fault),
    .o_access_fault (o_access_fault)
  );

endmodule

`default_nettype wire

//--- bench/tlb_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_asserts
  import mmu_pkg::*;
(
  input logic i_clk,
  input logic i_reset_n,
  input logic i_ready,
  input logic i_ptw_req_valid,
  input vpn_t i_ptw_req_vpn,
  input logic i_ptw_req_ready,
  input logic i_kill,
  input logic i_sfence_valid,
  input logic i_ptw_resp_valid,
  input logic i_tlb_update
);

  int n_fail = 0;

  // walker request level holds until taken or abandoned
  a_req_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_req_valid & ~i_ptw_req_ready & ~i_kill & ~i_sfence_valid
    |=> i_ptw_req_valid & $stable(i_ptw_req_vpn))
  else begin
    n_fail++;
    $error("walker request dropped or its VPN changed before acceptance");
  end

  // single cycle, and only after a walker reply
  a_update_pulse : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_tlb_update |-> i_ready & $past(i_ptw_resp_valid) & ~$past(i_tlb_update))
  else begin
    n_fail++;
    $error("tlb update without a preceding reply or held longer than one cycle");
  end

  // a walk that is neither killed nor flushed keeps ready low
  a_busy : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_req_valid & ~i_kill & (i_ptw_req_ready | ~i_sfence_valid)
    |=> ~i_ready)
  else begin
    n_fail++;
    $error("ready rose while the walk was still in progress");
  end

endmodule

bind tlb_refill_ctrl tlb_asserts u_asserts (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_ready          (o_ready),
  .i_ptw_req_valid  (o_ptw_req_valid),
  .i_ptw_req_vpn    (o_ptw_req_vpn),
  .i_ptw_req_ready  (i_ptw_req_ready),
  .i_kill           (i_kill),
  .i_sfence_valid   (i_sfence_valid),
  .i_ptw_resp_valid (i_ptw_resp_valid),
  .i_tlb_update     (o_tlb_update)
);

`default_nettype wire

//--- bench/tb_tlb.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tlb
  import mmu_pkg::*;
  import tlb_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_ROWS   = 18;

  // what a row does besides the lookup
  typedef logic [2:0] act_t;
  localparam act_t ACT_LOOKUP  = 3'd0;  // request valid, no walk expected
  localparam act_t ACT_PROBE   = 3'd1;  // request valid low
  localparam act_t ACT_FLUSH   = 3'd2;  // sfence first, then probe
  localparam act_t ACT_WALK    = 3'd3;
  localparam act_t ACT_SF_WAIT = 3'd4;  // sfence while waiting for the reply
  localparam act_t ACT_KILL    = 3'd5;

  // PTE flag bits, d a g u x w r v
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_U = 8'h10;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  typedef struct packed {
    act_t      act;
    priv_t     priv;
    logic      satp;
    logic      sum;
    logic      mxr;
    tlb_cmd_t  cmd;
    vaddr_t    vaddr;
    pte_t      pte;
    pg_level_t level;
    logic      ae;
    paddr_t    exp_paddr;
    logic      exp_miss;
    logic      exp_pf;
    logic      exp_af;
  } row_t;

  logic      i_clk;
  logic      i_reset_n;
  logic      i_req_valid;
  vaddr_t    i_req_vaddr;
  tlb_cmd_t  i_req_cmd;
  priv_t     i_priv;
  logic      i_satp_mode;
  logic      i_status_sum;
  logic      i_status_mxr;
  logic      i_sfence_valid;
  logic      i_kill;
  logic      i_ptw_req_ready;
  logic      i_ptw_resp_valid;
  pte_t      i_ptw_resp_pte;
  pg_level_t i_ptw_resp_level;
  logic      i_ptw_resp_ae;
  logic      o_ready;
  paddr_t    o_paddr;
  logic      o_miss;
  logic      o_page_fault;
  logic      o_access_fault;
  logic      o_ptw_req_valid;
  vpn_t      o_ptw_req_vpn;
  logic      o_tlb_update;

  row_t   rows [NUM_ROWS];
  string  row_names [NUM_ROWS];
  int     n_rows   = 0;
  int     n_checks = 0;
  int     n_errors = 0;
  integer seed     = 8951;

  tlb_top i_dut (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_valid      (i_req_valid),
    .i_req_vaddr      (i_req_vaddr),
    .i_req_cmd        (i_req_cmd),
    .i_priv           (i_priv),
    .i_satp_mode      (i_satp_mode),
    .i_status_sum     (i_status_sum),
    .i_status_mxr     (i_status_mxr),
    .i_sfence_valid   (i_sfence_valid),
    .i_kill           (i_kill),
    .i_ptw_req_ready  (i_ptw_req_ready),
    .i_ptw_resp_valid (i_ptw_resp_valid),
    .i_ptw_resp_pte   (i_ptw_resp_pte),
    .i_ptw_resp_level (i_ptw_resp_level),
    .i_ptw_resp_ae    (i_ptw_resp_ae),
    .o_ready          (o_ready),
    .o_paddr          (o_paddr),
    .o_miss           (o_miss),
    .o_page_fault     (o_page_fault),
    .o_access_fault   (o_access_fault),
    .o_ptw_req_valid  (o_ptw_req_valid),
    .o_ptw_req_vpn    (o_ptw_req_vpn),
    .o_tlb_update     (o_tlb_update)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(NUM_ROWS * 40 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $finish;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_vpn(input string name, input vpn_t exp, input vpn_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic next_cycle();
    @(posedge i_clk);
    #1;  // drive point
  endtask

  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    make_pte = {ppn, 2'b00, flags};
  endfunction

  task automatic add_row(input string name, input act_t act, input priv_t priv,
                         input logic satp, input logic sum, input logic mxr,
                         input tlb_cmd_t cmd, input vaddr_t vaddr, input ppn_t ppn,
                         input logic [7:0] flags, input pg_level_t level, input logic ae,
                         input paddr_t exp_paddr, input logic exp_miss,
                         input logic exp_pf, input logic exp_af);
    rows[n_rows] = '{act, priv, satp, sum, mxr, cmd, vaddr, make_pte(ppn, flags), level,
                     ae, exp_paddr, exp_miss, exp_pf, exp_af};
    row_names[n_rows] = name;
    n_rows++;
  endtask

  task automatic load_table();
    add_row("bare_satp_off", ACT_LOOKUP, PRIV_S, 1'b0, 1'b0, 1'b0, CMD_LOAD, 32'h8000_1234,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_8000_1234, 1'b0, 1'b0, 1'b0);
    add_row("bare_m_mode", ACT_LOOKUP, PRIV_M, 1'b1, 1'b0, 1'b0, CMD_STORE, 32'hC000_0ABC,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_C000_0ABC, 1'b0, 1'b0, 1'b0);
    add_row("refill_4k", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0040_1123,
            22'h12345, F_V | F_R | F_W | F_A | F_D, 1'b1, 1'b0, 34'h0_1234_5123,
            1'b0, 1'b0, 1'b0);
    add_row("hit_4k", ACT_LOOKUP, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_STORE, 32'h0040_1123,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_1234_5123, 1'b0, 1'b0, 1'b0);
    add_row("other_sector", ACT_PROBE, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0040_2123,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0, 1'b1, 1'b0, 1'b0);
    add_row("mega_refill", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0840_0010,
            22'h0ABC00, F_V | F_R | F_X | F_A, 1'b0, 1'b0, 34'h0_ABC0_0010, 1'b0, 1'b0, 1'b0);
    add_row("mega_hit", ACT_LOOKUP, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_FETCH, 32'h0877_F456,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_ABF7_F456, 1'b0, 1'b0, 1'b0);
    add_row("u_page_no_sum", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0100_3000,
            22'h00777, F_V | F_R | F_W | F_A | F_D | F_U, 1'b1, 1'b0, 34'h0_0077_7000,
            1'b0, 1'b1, 1'b0);
    add_row("u_page_sum", ACT_LOOKUP, PRIV_S, 1'b1, 1'b1, 1'b0, CMD_LOAD, 32'h0100_3000,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_0077_7000, 1'b0, 1'b0, 1'b0);
    add_row("u_page_u_mode", ACT_LOOKUP, PRIV_U, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0100_3000,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_0077_7000, 1'b0, 1'b0, 1'b0);
    add_row("xonly_no_mxr", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0200_5000,
            22'h00555, F_V | F_X | F_A, 1'b1, 1'b0, 34'h0_0055_5000, 1'b0, 1'b1, 1'b0);
    add_row("xonly_mxr", ACT_LOOKUP, PRIV_S, 1'b1, 1'b0, 1'b1, CMD_LOAD, 32'h0200_5000,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0_0055_5000, 1'b0, 1'b0, 1'b0);
    add_row("store_no_dirty", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_STORE, 32'h0300_6000,
            22'h00666, F_V | F_R | F_W | F_A, 1'b1, 1'b0, 34'h0_0066_6000, 1'b0, 1'b1, 1'b0);
    add_row("fetch_no_exec", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_FETCH, 32'h0400_7000,
            22'h00888, F_V | F_R | F_W | F_A | F_D, 1'b1, 1'b0, 34'h0_0088_8000,
            1'b0, 1'b1, 1'b0);
    add_row("access_fault", ACT_WALK, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0500_8000,
            22'h00999, F_V | F_R | F_A, 1'b1, 1'b1, 34'h0_0099_9000, 1'b0, 1'b0, 1'b1);
    add_row("sfence_flush", ACT_FLUSH, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0040_1123,
            22'h0, 8'h00, 1'b0, 1'b0, 34'h0, 1'b1, 1'b0, 1'b0);
    add_row("sfence_in_wait", ACT_SF_WAIT, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0600_9000,
            22'h00AAA, F_V | F_R | F_W | F_A | F_D, 1'b1, 1'b0, 34'h0, 1'b1, 1'b0, 1'b0);
    add_row("kill_walk", ACT_KILL, PRIV_S, 1'b1, 1'b0, 1'b0, CMD_LOAD, 32'h0700_A000,
            22'h00BBB, F_V | F_R | F_A, 1'b1, 1'b0, 34'h0, 1'b1, 1'b0, 1'b0);
  endtask

  // ------------------------------
  // walker model
  // ------------------------------
  task automatic serve_walk(input int idx);
    row_t  r;
    string nm;
    int    delay;
    int    n;
    logic  saw_update;
    r  = rows[idx];
    nm = row_names[idx];
    n  = 0;
    while (!o_ptw_req_valid && n < 8) begin
      next_cycle();
      n++;
    end
    if (!o_ptw_req_valid) begin
      n_errors++;
      $display("%s: the walker request was never raised", nm);
      return;
    end
    check_vpn({nm, " walk vpn"}, r.vaddr[31:12], o_ptw_req_vpn);
    check_flag({nm, " ready during walk"}, 1'b0, o_ready);
    delay = {$random(seed)} % 4;
    repeat (delay) next_cycle();  // back-pressure
    if (r.act == ACT_KILL) begin
      i_kill = 1'b1;
      next_cycle();
      i_kill = 1'b0;
      check_flag({nm, " ready after kill"}, 1'b1, o_ready);
      saw_update = 1'b0;
      repeat (3) begin
        saw_update = saw_update | o_tlb_update;
        next_cycle();
      end
      check_flag({nm, " update after kill"}, 1'b0, saw_update);
      return;
    end
    i_ptw_req_ready = 1'b1;
    next_cycle();
    i_ptw_req_ready = 1'b0;
    if (r.act == ACT_SF_WAIT) begin
      i_sfence_valid = 1'b1;
      next_cycle();
      i_sfence_valid = 1'b0;
    end
    delay = {$random(seed)} % 4;
    repeat (delay) next_cycle();
    i_ptw_resp_valid = 1'b1;
    i_ptw_resp_pte   = r.pte;
    i_ptw_resp_level = r.level;
    i_ptw_resp_ae    = r.ae;
    next_cycle();
    i_ptw_resp_valid = 1'b0;
    // first cycle back in ready
    check_flag({nm, " update after reply"}, 1'b1, o_tlb_update);
    check_flag({nm, " ready with update"}, 1'b1, o_ready);
    next_cycle();
    check_flag({nm, " update one cycle"}, 1'b0, o_tlb_update);
  endtask

  task automatic apply_row(input int idx);
    row_t  r;
    string nm;
    logic  walks;
    r     = rows[idx];
    nm    = row_names[idx];
    walks = (r.act == ACT_WALK) || (r.act == ACT_SF_WAIT) || (r.act == ACT_KILL);
    if (r.act == ACT_FLUSH) begin
      i_sfence_valid = 1'b1;
      next_cycle();
      i_sfence_valid = 1'b0;
    end
    i_priv       = r.priv;
    i_satp_mode  = r.satp;
    i_status_sum = r.sum;
    i_status_mxr = r.mxr;
    i_req_cmd    = r.cmd;
    i_req_vaddr  = r.vaddr;
    i_req_valid  = (r.act == ACT_LOOKUP) || walks;
    #3;
    if (walks) begin
      check_flag({nm, " first miss"}, 1'b1, o_miss);
      check_flag({nm, " fault on miss"}, 1'b0, o_page_fault | o_access_fault);
      next_cycle();
      i_req_valid = 1'b0;
      serve_walk(idx);
      #3;  // repeat the lookup
    end
    if (!r.exp_miss) check_paddr({nm, " paddr"}, r.exp_paddr, o_paddr);
    check_flag({nm, " miss"}, r.exp_miss, o_miss);
    check_flag({nm, " page fault"}, r.exp_pf, o_page_fault);
    check_flag({nm, " access fault"}, r.exp_af, o_access_fault);
    next_cycle();
    i_req_valid = 1'b0;
    if (r.act == ACT_LOOKUP) check_flag({nm, " no walk"}, 1'b0, o_ptw_req_valid);
    next_cycle();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int n_asrt;
    i_reset_n        = 1'b0;
    i_req_valid      = 1'b0;
    i_req_vaddr      = '0;
    i_req_cmd        = CMD_LOAD;
    i_priv           = PRIV_S;
    i_satp_mode      = 1'b0;
    i_status_sum     = 1'b0;
    i_status_mxr     = 1'b0;
    i_sfence_valid   = 1'b0;
    i_kill           = 1'b0;
    i_ptw_req_ready  = 1'b0;
    i_ptw_resp_valid = 1'b0;
    i_ptw_resp_pte   = '0;
    i_ptw_resp_level = '0;
    i_ptw_resp_ae    = 1'b0;
    load_table();
    repeat (2) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    #3;
    check_flag("reset ready", 1'b1, o_ready);
    check_flag("reset walk request", 1'b0, o_ptw_req_valid);
    check_flag("reset update", 1'b0, o_tlb_update);
    next_cycle();
    for (int i = 0; i < n_rows; i++) apply_row(i);
    n_asrt = i_dut.u_refill_ctrl.u_asserts.n_fail;
    $display("checks run: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, n_asrt);
    if (n_errors == 0 && n_asrt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/tlb_pkg.sv
rtl/tlb_lookup.sv
rtl/tlb_entry_store.sv
rtl/tlb_refill_ctrl.sv
rtl/tlb_perm_check.sv
rtl/tlb_top.sv
bench/tlb_asserts.sv
bench/tb_tlb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_tlb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
